//--- common/mem_sub_pkg.sv
`default_nettype none

// ------------------------------------------------
// Shared definitions for the memory subsystem
// ------------------------------------------------
package mem_sub_pkg;

	// Data and address width
	parameter int xlen = 32;

	// Byte lanes per word
	parameter int xbytes = xlen / 8;

	// Operation requested by the core control side
	typedef enum logic [1:0] {
		LSU_NULL  = 2'd0,
		LSU_LOAD  = 2'd1,
		LSU_STORE = 2'd2
	} lsu_op_t;

	// Access size, also carried on the bus size field
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} lsu_size_t;

	// Encoding 3 is unused
	// Decoders treat it like a word access

endpackage

`default_nettype wire

//--- compile.f
common/mem_sub_pkg.sv
lsu/lsu.sv
logic/ifu_fetch.sv
logic/icb_arbiter.sv
logic/data_ram.sv
logic/mem_sub_top.sv
tb/mem_sub_checker.sv
tb/mem_sub_tb.sv

//--- logic/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
	parameter int RAM_DEPTH = 256
) (
	input  wire                           clk,
	input  wire                           rst_n,
	// Bus slave port
	input  wire                           cmd_valid,
	output logic                          cmd_ready,
	input  wire                           cmd_read,
	input  wire [mem_sub_pkg::xlen-1:0]   cmd_addr,
	input  wire [mem_sub_pkg::xlen-1:0]   cmd_wdata,
	input  mem_sub_pkg::lsu_size_t        cmd_size,
	output logic                          rsp_valid,
	input  wire                           rsp_ready,
	output logic [mem_sub_pkg::xlen-1:0]  rsp_rdata,
	output logic                          rsp_err
);
	import mem_sub_pkg::*;

	localparam int AW = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

	logic [xlen-1:0]   mem [RAM_DEPTH];
	logic [xlen-3:0]   word_addr;
	logic [AW-1:0]     idx;
	logic              in_range;
	logic              accept;
	logic [xbytes-1:0] lane_mask;
	logic [xlen-1:0]   wdata_sh;

	// ------------------------------------------------
	// Address decode
	// ------------------------------------------------
	assign word_addr = cmd_addr[xlen-1:2];
	assign idx       = word_addr[AW-1:0];
	assign in_range  = (word_addr < (xlen-2)'(RAM_DEPTH));

	// Busy only while a response waits
	assign cmd_ready = ~rsp_valid;
	assign accept    = cmd_valid & cmd_ready;

	// Low bytes of wdata go to lanes from the offset up
	always_comb begin
		case (cmd_size)
			SIZE_BYTE: lane_mask = xbytes'(4'b0001) << cmd_addr[1:0];
			SIZE_HALF: lane_mask = xbytes'(4'b0011) << cmd_addr[1:0];
			default:   lane_mask = xbytes'(4'b1111) << cmd_addr[1:0];
		endcase
	end

	assign wdata_sh = cmd_wdata << {cmd_addr[1:0], 3'b000};

	// Array starts cleared, errored writes are dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < RAM_DEPTH; i++)
				mem[i] <= '0;
		end else if (accept & ~cmd_read & in_range) begin
			for (int b = 0; b < xbytes; b++) begin
				if (lane_mask[b])
					mem[idx][8*b +: 8] <= wdata_sh[8*b +: 8];
			end
		end
	end

	// ------------------------------------------------
	// Response, one cycle after acceptance
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else if (accept)
			rsp_valid <= 1'b1;
		else if (rsp_ready)
			rsp_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_err   <= ~in_range;
			// Zero for writes and out of range reads
			rsp_rdata <= (cmd_read & in_range) ? mem[idx] : '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/icb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module icb_arbiter (
	input  wire                           clk,
	input  wire                           rst_n,
	// LSU side, high priority
	input  wire                           lsu_cmd_valid,
	output logic                          lsu_cmd_ready,
	input  wire                           lsu_cmd_read,
	input  wire [mem_sub_pkg::xlen-1:0]   lsu_cmd_addr,
	input  wire [mem_sub_pkg::xlen-1:0]   lsu_cmd_wdata,
	input  mem_sub_pkg::lsu_size_t        lsu_cmd_size,
	output logic                          lsu_rsp_valid,
	input  wire                           lsu_rsp_ready,
	output logic [mem_sub_pkg::xlen-1:0]  lsu_rsp_rdata,
	output logic                          lsu_rsp_err,
	// IFU side
	input  wire                           ifu_cmd_valid,
	output logic                          ifu_cmd_ready,
	input  wire                           ifu_cmd_read,
	input  wire [mem_sub_pkg::xlen-1:0]   ifu_cmd_addr,
	input  wire [mem_sub_pkg::xlen-1:0]   ifu_cmd_wdata,
	input  mem_sub_pkg::lsu_size_t        ifu_cmd_size,
	output logic                          ifu_rsp_valid,
	input  wire                           ifu_rsp_ready,
	output logic [mem_sub_pkg::xlen-1:0]  ifu_rsp_rdata,
	output logic                          ifu_rsp_err,
	// RAM side
	output logic                          ram_cmd_valid,
	input  wire                           ram_cmd_ready,
	output logic                          ram_cmd_read,
	output logic [mem_sub_pkg::xlen-1:0]  ram_cmd_addr,
	output logic [mem_sub_pkg::xlen-1:0]  ram_cmd_wdata,
	output mem_sub_pkg::lsu_size_t        ram_cmd_size,
	input  wire                           ram_rsp_valid,
	output logic                          ram_rsp_ready,
	input  wire [mem_sub_pkg::xlen-1:0]   ram_rsp_rdata,
	input  wire                           ram_rsp_err
);
	// Grant held from command to response
	logic lock;
	// 0 LSU, 1 IFU
	logic owner_ifu;
	// IFU wins only when the LSU is idle
	logic pick_ifu;

	assign pick_ifu = ~lsu_cmd_valid;

	// ------------------------------------------------
	// Command mux
	// ------------------------------------------------
	assign ram_cmd_valid = ~lock & (lsu_cmd_valid | ifu_cmd_valid);
	assign ram_cmd_read  = pick_ifu ? ifu_cmd_read  : lsu_cmd_read;
	assign ram_cmd_addr  = pick_ifu ? ifu_cmd_addr  : lsu_cmd_addr;
	assign ram_cmd_wdata = pick_ifu ? ifu_cmd_wdata : lsu_cmd_wdata;
	assign ram_cmd_size  = pick_ifu ? ifu_cmd_size  : lsu_cmd_size;

	// Loser and locked-out masters just wait
	assign lsu_cmd_ready = ~lock & ram_cmd_ready;
	assign ifu_cmd_ready = ~lock & pick_ifu & ram_cmd_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock      <= 1'b0;
			owner_ifu <= 1'b0;
		end else if (ram_cmd_valid & ram_cmd_ready) begin
			lock      <= 1'b1;
			owner_ifu <= pick_ifu;
		end else if (ram_rsp_valid & ram_rsp_ready) begin
			lock      <= 1'b0;
			owner_ifu <= 1'b0;
		end
	end

	// ------------------------------------------------
	// Response routing, owner only
	// ------------------------------------------------
	assign lsu_rsp_valid = lock & ~owner_ifu & ram_rsp_valid;
	assign ifu_rsp_valid = lock & owner_ifu & ram_rsp_valid;
	assign ram_rsp_ready = lock & (owner_ifu ? ifu_rsp_ready : lsu_rsp_ready);

	// Payload shared, qualified by rsp_valid
	assign lsu_rsp_rdata = ram_rsp_rdata;
	assign ifu_rsp_rdata = ram_rsp_rdata;
	assign lsu_rsp_err   = ram_rsp_err;
	assign ifu_rsp_err   = ram_rsp_err;

endmodule

`default_nettype wire

//--- logic/ifu_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_fetch #(
	parameter logic [mem_sub_pkg::xlen-1:0] FETCH_BASE = '0
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           fetch_en,
	// Fetched instruction pulses once per response
	output logic                          fetch_valid,
	output logic [mem_sub_pkg::xlen-1:0]  fetch_pc,
	output logic [mem_sub_pkg::xlen-1:0]  fetch_instr,
	// Bus master port
	output logic                          cmd_valid,
	input  wire                           cmd_ready,
	output logic                          cmd_read,
	output logic [mem_sub_pkg::xlen-1:0]  cmd_addr,
	output logic [mem_sub_pkg::xlen-1:0]  cmd_wdata,
	output mem_sub_pkg::lsu_size_t        cmd_size,
	input  wire                           rsp_valid,
	output logic                          rsp_ready,
	input  wire [mem_sub_pkg::xlen-1:0]   rsp_rdata,
	input  wire                           rsp_err
);
	import mem_sub_pkg::*;

	logic [xlen-1:0] pc;
	// One read in flight
	logic            pending;
	logic            rsp_fire;

	// ------------------------------------------------
	// Read command at pc
	// ------------------------------------------------
	assign cmd_valid = fetch_en & ~pending;
	assign cmd_read  = 1'b1;
	assign cmd_addr  = pc;
	// Never writes
	assign cmd_wdata = '0;
	assign cmd_size  = SIZE_WORD;
	assign rsp_ready = 1'b1;

	assign rsp_fire = rsp_valid & rsp_ready & pending;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			pc      <= FETCH_BASE;
		end else if (rsp_fire) begin
			// Next sequential word
			pending <= 1'b0;
			pc      <= pc + xlen'(4);
		end else if (cmd_valid & cmd_ready) begin
			pending <= 1'b1;
		end
	end

	// ------------------------------------------------
	// Fetch result
	// ------------------------------------------------
	// pc still points at the word being returned
	assign fetch_valid = rsp_fire;
	assign fetch_pc    = pc;
	// Errored reads already come back as zero
	assign fetch_instr = rsp_rdata;

endmodule

`default_nettype wire

//--- logic/mem_sub_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_sub_top #(
	parameter int                           RAM_DEPTH  = 256,
	parameter logic [mem_sub_pkg::xlen-1:0] FETCH_BASE = '0
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           flush,
	// LSU control and result
	input  mem_sub_pkg::lsu_op_t          lsu_op,
	input  wire [mem_sub_pkg::xlen-1:0]   lsu_addr,
	input  wire [mem_sub_pkg::xlen-1:0]   store_data,
	input  mem_sub_pkg::lsu_size_t        lsu_size,
	input  wire                           lsu_unsign,
	output logic [mem_sub_pkg::xlen-1:0]  wb_data,
	output logic                          wb_valid,
	output logic                          lsu_done,
	output logic                          lsu_err,
	// Fetch
	input  wire                           fetch_en,
	output logic                          fetch_valid,
	output logic [mem_sub_pkg::xlen-1:0]  fetch_pc,
	output logic [mem_sub_pkg::xlen-1:0]  fetch_instr
);
	import mem_sub_pkg::*;

	// ------------------------------------------------
	// Bus wires, one group per master and one to RAM
	// ------------------------------------------------
	logic            lsu_cmd_valid, lsu_cmd_ready, lsu_cmd_read;
	logic [xlen-1:0] lsu_cmd_addr, lsu_cmd_wdata, lsu_rsp_rdata;
	lsu_size_t       lsu_cmd_size;
	logic            lsu_rsp_valid, lsu_rsp_ready, lsu_rsp_err;

	logic            ifu_cmd_valid, ifu_cmd_ready, ifu_cmd_read;
	logic [xlen-1:0] ifu_cmd_addr, ifu_cmd_wdata, ifu_rsp_rdata;
	lsu_size_t       ifu_cmd_size;
	logic            ifu_rsp_valid, ifu_rsp_ready, ifu_rsp_err;

	logic            ram_cmd_valid, ram_cmd_ready, ram_cmd_read;
	logic [xlen-1:0] ram_cmd_addr, ram_cmd_wdata, ram_rsp_rdata;
	lsu_size_t       ram_cmd_size;
	logic            ram_rsp_valid, ram_rsp_ready, ram_rsp_err;

	lsu lsu_i (
		.clk, .rst_n, .flush,
		.lsu_op, .lsu_addr, .store_data, .lsu_size, .lsu_unsign,
		.wb_data, .wb_valid, .lsu_done, .lsu_err,
		.cmd_valid (lsu_cmd_valid), .cmd_ready (lsu_cmd_ready),
		.cmd_read  (lsu_cmd_read),  .cmd_addr  (lsu_cmd_addr),
		.cmd_wdata (lsu_cmd_wdata), .cmd_size  (lsu_cmd_size),
		.rsp_valid (lsu_rsp_valid), .rsp_ready (lsu_rsp_ready),
		.rsp_rdata (lsu_rsp_rdata), .rsp_err   (lsu_rsp_err)
	);

	ifu_fetch #(.FETCH_BASE(FETCH_BASE)) ifu_fetch_i (
		.clk, .rst_n, .fetch_en,
		.fetch_valid, .fetch_pc, .fetch_instr,
		.cmd_valid (ifu_cmd_valid), .cmd_ready (ifu_cmd_ready),
		.cmd_read  (ifu_cmd_read),  .cmd_addr  (ifu_cmd_addr),
		.cmd_wdata (ifu_cmd_wdata), .cmd_size  (ifu_cmd_size),
		.rsp_valid (ifu_rsp_valid), .rsp_ready (ifu_rsp_ready),
		.rsp_rdata (ifu_rsp_rdata), .rsp_err   (ifu_rsp_err)
	);

	// LSU first, grant locked until the response
	icb_arbiter icb_arbiter_i (
		.clk, .rst_n,
		.lsu_cmd_valid, .lsu_cmd_ready, .lsu_cmd_read, .lsu_cmd_addr,
		.lsu_cmd_wdata, .lsu_cmd_size, .lsu_rsp_valid, .lsu_rsp_ready,
		.lsu_rsp_rdata, .lsu_rsp_err,
		.ifu_cmd_valid, .ifu_cmd_ready, .ifu_cmd_read, .ifu_cmd_addr,
		.ifu_cmd_wdata, .ifu_cmd_size, .ifu_rsp_valid, .ifu_rsp_ready,
		.ifu_rsp_rdata, .ifu_rsp_err,
		.ram_cmd_valid, .ram_cmd_ready, .ram_cmd_read, .ram_cmd_addr,
		.ram_cmd_wdata, .ram_cmd_size, .ram_rsp_valid, .ram_rsp_ready,
		.ram_rsp_rdata, .ram_rsp_err
	);

	data_ram #(.RAM_DEPTH(RAM_DEPTH)) data_ram_i (
		.clk, .rst_n,
		.cmd_valid (ram_cmd_valid), .cmd_ready (ram_cmd_ready),
		.cmd_read  (ram_cmd_read),  .cmd_addr  (ram_cmd_addr),
		.cmd_wdata (ram_cmd_wdata), .cmd_size  (ram_cmd_size),
		.rsp_valid (ram_rsp_valid), .rsp_ready (ram_rsp_ready),
		.rsp_rdata (ram_rsp_rdata), .rsp_err   (ram_rsp_err)
	);

endmodule

`default_nettype wire

//--- lsu/lsu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           flush,
	// Core control side, held until lsu_done
	input  mem_sub_pkg::lsu_op_t          lsu_op,
	input  wire [mem_sub_pkg::xlen-1:0]   lsu_addr,
	input  wire [mem_sub_pkg::xlen-1:0]   store_data,
	input  mem_sub_pkg::lsu_size_t        lsu_size,
	input  wire                           lsu_unsign,
	// Result side
	output logic [mem_sub_pkg::xlen-1:0]  wb_data,
	output logic                          wb_valid,
	output logic                          lsu_done,
	output logic                          lsu_err,
	// Bus master port
	output logic                          cmd_valid,
	input  wire                           cmd_ready,
	output logic                          cmd_read,
	output logic [mem_sub_pkg::xlen-1:0]  cmd_addr,
	output logic [mem_sub_pkg::xlen-1:0]  cmd_wdata,
	output mem_sub_pkg::lsu_size_t        cmd_size,
	input  wire                           rsp_valid,
	output logic                          rsp_ready,
	input  wire [mem_sub_pkg::xlen-1:0]   rsp_rdata,
	input  wire                           rsp_err
);
	import mem_sub_pkg::*;

	// 0 address phase, 1 data phase
	logic            phase;
	// Captured at issue
	logic [1:0]      off_q;
	logic            load_q;
	logic            cmd_fire;
	logic            rsp_fire;
	logic [xlen-1:0] rdata_shift;

	// ------------------------------------------------
	// Command side
	// ------------------------------------------------
	// Issue as soon as the op is seen, unless flushing
	assign cmd_valid = (lsu_op != LSU_NULL) & ~phase & ~flush;
	// Anything not a store reads
	assign cmd_read  = (lsu_op != LSU_STORE);
	assign cmd_addr  = lsu_addr;
	assign cmd_wdata = store_data;
	assign cmd_size  = lsu_size;

	// Always able to sink a response
	assign rsp_ready = 1'b1;

	assign cmd_fire = cmd_valid & cmd_ready;
	assign rsp_fire = rsp_valid & rsp_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= 1'b0;
		end else if (cmd_fire) begin
			phase <= 1'b1;
		end else if (rsp_fire) begin
			phase <= 1'b0;
		end
	end

	// Offset and direction of the accepted command
	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			off_q  <= lsu_addr[1:0];
			load_q <= (lsu_op == LSU_LOAD);
		end
	end

	// ------------------------------------------------
	// Response side and load alignment
	// ------------------------------------------------
	// Bring the addressed byte down to lane 0
	assign rdata_shift = rsp_rdata >> {off_q, 3'b000};

	always_comb begin
		case (lsu_size)
			SIZE_BYTE: begin
				if (lsu_unsign)
					wb_data = {{(xlen-8){1'b0}}, rdata_shift[7:0]};
				else
					wb_data = {{(xlen-8){rdata_shift[7]}}, rdata_shift[7:0]};
			end
			SIZE_HALF: begin
				if (lsu_unsign)
					wb_data = {{(xlen-16){1'b0}}, rdata_shift[15:0]};
				else
					wb_data = {{(xlen-16){rdata_shift[15]}}, rdata_shift[15:0]};
			end
			// Word, no extension needed
			default: wb_data = rdata_shift;
		endcase
	end

	// Done in the response cycle, stores included
	assign lsu_done = phase & rsp_fire;
	assign wb_valid = lsu_done & load_q;
	assign lsu_err  = lsu_done & rsp_err;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module mem_sub_tb -Mdir obj_dir -f compile.f

out=$(./obj_dir/Vmem_sub_tb)
printf '%s\n' "$out"

# Non-zero exit unless the pass line is present
printf '%s\n' "$out" | grep -qx "Testbench passed"

//--- tb/mem_sub_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mem_sub_checker #(
	parameter int                           RAM_DEPTH  = 256,
	parameter logic [mem_sub_pkg::xlen-1:0] FETCH_BASE = '0
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           flush,
	// Operation under test
	input  mem_sub_pkg::lsu_op_t          lsu_op,
	input  wire [mem_sub_pkg::xlen-1:0]   lsu_addr,
	input  wire [mem_sub_pkg::xlen-1:0]   store_data,
	input  mem_sub_pkg::lsu_size_t        lsu_size,
	input  wire [7:0]                     test_id,
	input  wire [mem_sub_pkg::xlen-1:0]   exp_rdata,
	input  wire                           exp_err,
	// DUT results
	input  wire [mem_sub_pkg::xlen-1:0]   wb_data,
	input  wire                           wb_valid,
	input  wire                           lsu_done,
	input  wire                           lsu_err,
	input  wire                           fetch_valid,
	input  wire [mem_sub_pkg::xlen-1:0]   fetch_pc,
	input  wire [mem_sub_pkg::xlen-1:0]   fetch_instr,
	// Running totals
	output int                            pass_count,
	output int                            fail_count,
	output int                            fetch_count,
	output int                            fetch_errors
);
	import mem_sub_pkg::*;

	// Byte image of the RAM, zero like the RAM after reset
	logic [7:0]      model [RAM_DEPTH*4];
	logic [xlen-1:0] exp_pc;

	initial begin
		for (int i = 0; i < RAM_DEPTH*4; i++)
			model[i] = 8'h00;
	end

	// Word index below the depth
	function automatic logic in_range(input logic [xlen-1:0] addr);
		return {2'b00, addr[xlen-1:2]} < xlen'(RAM_DEPTH);
	endfunction

	function automatic logic [xlen-1:0] model_word(input logic [xlen-1:0] addr);
		int base;
		base = int'({addr[xlen-1:2], 2'b00});
		if (!in_range(addr))
			return '0;
		return {model[base+3], model[base+2], model[base+1], model[base]};
	endfunction

	// Low bytes of the data into lanes from the offset up
	task automatic apply_store();
		int base;
		int nbytes;
		int lane;
		base = int'({lsu_addr[xlen-1:2], 2'b00});
		case (lsu_size)
			SIZE_BYTE: nbytes = 1;
			SIZE_HALF: nbytes = 2;
			default:   nbytes = 4;
		endcase
		for (int k = 0; k < nbytes; k++) begin
			lane = int'(lsu_addr[1:0]) + k;
			if (lane < 4)
				model[base + lane] = store_data[8*k +: 8];
		end
	endtask

	// ------------------------------------------------
	// LSU result, one line per test
	// ------------------------------------------------
	task automatic check_result();
		logic ok;
		ok = 1'b1;
		if (lsu_err !== exp_err) begin
			$display("CHECK FAILED test %02h lsu_err got %h expected %h",
				test_id, lsu_err, exp_err);
			ok = 1'b0;
		end
		if (lsu_op == LSU_LOAD) begin
			if (wb_valid !== 1'b1) begin
				$display("test %02h: load completed without write-back", test_id);
				ok = 1'b0;
			end else if (wb_data !== exp_rdata) begin
				$display("CHECK FAILED test %02h wb_data got %h expected %h",
					test_id, wb_data, exp_rdata);
				ok = 1'b0;
			end
		end else if (wb_valid !== 1'b0) begin
			$display("test %02h: write-back raised on a store", test_id);
			ok = 1'b0;
		end
		// Flush only ever rises on an idle LSU
		if (flush) begin
			$display("test %02h: operation completed while flush was held", test_id);
			ok = 1'b0;
		end
		if (lsu_op == LSU_STORE && in_range(lsu_addr))
			apply_store();
		if (ok) begin
			pass_count++;
			$display("test %02h %s passed", test_id, (lsu_op == LSU_LOAD) ? "load" : "store");
		end else begin
			fail_count++;
			$display("test %02h %s failed", test_id, (lsu_op == LSU_LOAD) ? "load" : "store");
		end
	endtask

	// ------------------------------------------------
	// Fetch stream against the model
	// ------------------------------------------------
	task automatic check_fetch();
		logic [xlen-1:0] want_instr;
		fetch_count++;
		if (fetch_pc !== exp_pc) begin
			$display("CHECK FAILED fetch_pc got %h expected %h", fetch_pc, exp_pc);
			fetch_errors++;
		end else begin
			want_instr = model_word(fetch_pc);
			if (fetch_instr !== want_instr) begin
				$display("CHECK FAILED fetch_instr at %h got %h expected %h",
					fetch_pc, fetch_instr, want_instr);
				fetch_errors++;
			end
		end
		exp_pc = exp_pc + xlen'(4);
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			exp_pc       = FETCH_BASE;
			pass_count   = 0;
			fail_count   = 0;
			fetch_count  = 0;
			fetch_errors = 0;
		end else begin
			if (lsu_done)
				check_result();
			if (fetch_valid)
				check_fetch();
		end
	end

endmodule

`default_nettype wire

//--- tb/mem_sub_input.txt
# id op addr size unsign store_data exp_rdata exp_err fetch_en flush_hold
# op 1 load 2 store, size 0 byte 1 half 2 word, every field hex
# Word store and load back
01 2 00000100 2 0 deadbeef 00000000 0 0 00
02 1 00000100 2 0 00000000 deadbeef 0 0 00
03 2 00000104 2 0 12345678 00000000 0 0 00
04 1 00000104 2 0 00000000 12345678 0 0 00
# Byte and half loads at each offset, signed and unsigned
05 2 00000108 2 0 8af769f0 00000000 0 0 00
06 1 00000108 0 0 00000000 fffffff0 0 0 00
07 1 00000108 0 1 00000000 000000f0 0 0 00
08 1 00000109 0 0 00000000 00000069 0 0 00
09 1 00000109 0 1 00000000 00000069 0 0 00
0a 1 0000010a 0 0 00000000 fffffff7 0 0 00
0b 1 0000010a 0 1 00000000 000000f7 0 0 00
0c 1 0000010b 0 0 00000000 ffffff8a 0 0 00
0d 1 0000010b 0 1 00000000 0000008a 0 0 00
0e 1 00000108 1 0 00000000 000069f0 0 0 00
0f 1 00000108 1 1 00000000 000069f0 0 0 00
10 1 00000109 1 0 00000000 fffff769 0 0 00
11 1 00000109 1 1 00000000 0000f769 0 0 00
12 1 0000010a 1 0 00000000 ffff8af7 0 0 00
13 1 0000010a 1 1 00000000 00008af7 0 0 00
# Sub-word stores into one word
14 2 0000010c 2 0 11223344 00000000 0 0 00
15 2 0000010d 0 0 000000aa 00000000 0 0 00
16 2 0000010e 1 0 ffffbeef 00000000 0 0 00
17 1 0000010c 2 0 00000000 beefaa44 0 0 00
18 2 0000010c 0 0 12345655 00000000 0 0 00
19 1 0000010c 2 0 00000000 beefaa55 0 0 00
1a 1 00000108 2 0 00000000 8af769f0 0 0 00
# Out of range, aliasing word 0 must stay clear
1b 1 00000400 2 0 00000000 00000000 1 0 00
1c 2 00000400 2 0 cafef00d 00000000 1 0 00
1d 2 00001000 0 0 000000ee 00000000 1 0 00
1e 1 00000000 2 0 00000000 00000000 0 0 00
# Fetch running alongside
1f 2 00000000 2 0 00000013 00000000 0 1 00
20 2 00000004 2 0 00a00093 00000000 0 1 00
21 2 0000000c 0 0 0000006f 00000000 0 1 00
22 1 00000004 2 0 00000000 00a00093 0 1 00
23 1 00000006 0 0 00000000 ffffffa0 0 1 00
24 1 00000000 1 0 00000000 00000013 0 1 00
25 1 00000108 2 0 00000000 8af769f0 0 1 00
# Flush held for ten cycles with the op pending
26 1 00000104 2 0 00000000 12345678 0 1 0a
27 2 00000107 0 0 0000009c 00000000 0 1 0a
28 1 00000104 2 0 00000000 9c345678 0 1 00

//--- tb/mem_sub_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_sub_tb;
	import mem_sub_pkg::*;

	localparam int              RAM_DEPTH   = 256;
	localparam logic [xlen-1:0] FETCH_BASE  = '0;
	// Cycle budget per vector, covers a flush hold plus arbitration
	localparam int              LINE_CYCLES = 20;
	// Fields per vector line
	localparam int              NCOL        = 10;

	logic            clk;
	logic            rst_n;
	logic            flush;
	lsu_op_t         lsu_op;
	logic [xlen-1:0] lsu_addr;
	logic [xlen-1:0] store_data;
	lsu_size_t       lsu_size;
	logic            lsu_unsign;
	logic            fetch_en;
	logic [xlen-1:0] wb_data;
	logic            wb_valid;
	logic            lsu_done;
	logic            lsu_err;
	logic            fetch_valid;
	logic [xlen-1:0] fetch_pc;
	logic [xlen-1:0] fetch_instr;

	// Expected values for the checker
	logic [7:0]      test_id;
	logic [xlen-1:0] exp_rdata;
	logic            exp_err;

	int              pass_count;
	int              fail_count;
	int              fetch_count;
	int              fetch_errors;

	// All vector fields, NCOL words per line
	logic [31:0]     vec [$];
	int              cycle_limit = 0;
	int              cycles;

	mem_sub_top #(
		.RAM_DEPTH  (RAM_DEPTH),
		.FETCH_BASE (FETCH_BASE)
	) mem_sub_top_i (
		.clk, .rst_n, .flush,
		.lsu_op, .lsu_addr, .store_data, .lsu_size, .lsu_unsign,
		.wb_data, .wb_valid, .lsu_done, .lsu_err,
		.fetch_en, .fetch_valid, .fetch_pc, .fetch_instr
	);

	mem_sub_checker #(
		.RAM_DEPTH  (RAM_DEPTH),
		.FETCH_BASE (FETCH_BASE)
	) mem_sub_checker_i (
		.clk, .rst_n, .flush,
		.lsu_op, .lsu_addr, .store_data, .lsu_size,
		.test_id, .exp_rdata, .exp_err,
		.wb_data, .wb_valid, .lsu_done, .lsu_err,
		.fetch_valid, .fetch_pc, .fetch_instr,
		.pass_count, .fail_count, .fetch_count, .fetch_errors
	);

	// ------------------------------------------------
	// Clock and timeout
	// ------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Armed once the vector count is known
	initial begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycle_limit);
		$display("Testbench failed");
		$finish;
	end

	// ------------------------------------------------
	// Vector file and stimulus
	// ------------------------------------------------
	// Lines that do not parse into NCOL hex fields are skipped
	task automatic load_vectors(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [NCOL];
		ok = 1'b0;
		fd = $fopen("tb/mem_sub_input.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
					if (n == NCOL)
						foreach (f[c])
							vec.push_back(f[c]);
				end
			end
			$fclose(fd);
		end
	endtask

	// One operation, held until lsu_done
	task automatic run_vector(input int b);
		int hold;
		hold = int'(vec[b+9]);
		@(posedge clk);
		test_id    <= vec[b][7:0];
		lsu_op     <= lsu_op_t'(vec[b+1][1:0]);
		lsu_addr   <= vec[b+2];
		lsu_size   <= lsu_size_t'(vec[b+3][1:0]);
		lsu_unsign <= vec[b+4][0];
		store_data <= vec[b+5];
		exp_rdata  <= vec[b+6];
		exp_err    <= vec[b+7][0];
		fetch_en   <= vec[b+8][0];
		flush      <= (hold > 0);
		// Flush window with the op pending
		if (hold > 0) begin
			repeat (hold) @(posedge clk);
			flush <= 1'b0;
		end
		@(posedge clk);
		while (lsu_done !== 1'b1)
			@(posedge clk);
		lsu_op <= LSU_NULL;
	endtask

	initial begin
		bit ok;
		int nvec;
		rst_n      = 1'b0;
		flush      = 1'b0;
		lsu_op     = LSU_NULL;
		lsu_addr   = '0;
		store_data = '0;
		lsu_size   = SIZE_WORD;
		lsu_unsign = 1'b0;
		fetch_en   = 1'b0;
		test_id    = '0;
		exp_rdata  = '0;
		exp_err    = 1'b0;
		load_vectors(ok);
		nvec = vec.size() / NCOL;
		if (!ok || nvec == 0) begin
			$display("No test vectors could be read from tb/mem_sub_input.txt");
			$display("Testbench failed");
			$finish;
		end else begin
			cycle_limit = nvec * LINE_CYCLES + 200;
			repeat (2) @(posedge clk);
			rst_n <= 1'b1;
			for (int i = 0; i < nvec; i++)
				run_vector(NCOL * i);
			@(posedge clk);
			fetch_en <= 1'b0;
			// Drain a fetch still in flight
			repeat (4) @(posedge clk);
			$display("Summary: %0d tests passed, %0d failed, %0d fetches, %0d fetch errors",
				pass_count, fail_count, fetch_count, fetch_errors);
			if (fail_count == 0 && fetch_errors == 0 && pass_count == nvec && fetch_count > 0)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
